// File: rtl/memOpPkg.sv
`default_nettype none

package memOpPkg;

    localparam int OpWidth = 4;
    localparam int SizeWidth = 2;

    // memory operation codes as the CPU decodes them
    typedef enum logic [OpWidth-1:0] {
        NONE = 4'd0,
        LB   = 4'd1,
        LH   = 4'd2,
        LW   = 4'd3,
        LBU  = 4'd4,
        LHU  = 4'd5,
        SB   = 4'd6,
        SH   = 4'd7,
        SW   = 4'd8
    } memOpT;

    typedef enum logic [SizeWidth-1:0] {
        BYTE = 2'd0,
        HALF = 2'd1,
        WORD = 2'd2
    } accessSizeT;

    // unused codes fall out of both sets, so they act like NONE
    function automatic logic isLoad(memOpT op);
        return op inside {LB, LH, LW, LBU, LHU};
    endfunction

    function automatic logic isStore(memOpT op);
        return op inside {SB, SH, SW};
    endfunction

    function automatic accessSizeT sizeOf(memOpT op);
        case (op)
            LB, LBU, SB: return BYTE;
            LH, LHU, SH: return HALF;
            default:     return WORD;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: rtl/busMapPkg.sv
`default_nettype none

package busMapPkg;

    // bus and register width
    localparam int DataWidth = 32;
    localparam int SelWidth = DataWidth / 8;  // one select bit per byte lane

    typedef logic [DataWidth-1:0] wordT;
    typedef logic [SelWidth-1:0] selT;

    // byte selects, always lane 0 upward
    localparam selT SelByte = 4'b0001;
    localparam selT SelHalf = 4'b0011;
    localparam selT SelWord = 4'b1111;

    // memory returns this for an unmapped or empty instruction slot
    localparam wordT InvalidInstr = 32'hDEADBEEF;

endpackage

`default_nettype wire

// File: rtl/fetchStage.sv
`timescale 1ns/1ps
`default_nettype none

module fetchStage (
    input  wire logic             clk,
    input  wire logic             nrst,
    input  wire logic             start_i,      // one cycle after release
    input  busMapPkg::wordT       pc_i,
    output logic                  busCyc_o,
    output busMapPkg::wordT       busAdr_o,
    input  wire logic             busAck_i,
    input  busMapPkg::wordT       busDat_i,
    output busMapPkg::wordT       instr_o,
    output busMapPkg::wordT       pc_o,
    output logic                  fetchDone_o
);

    logic firstFetch;  // kicks the very first read after reset
    logic ackSeen;

    assign ackSeen = busCyc_o && busAck_i;

    // address comes straight from the CPU, which holds it while frozen
    assign busAdr_o = pc_i;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            firstFetch  <= 1'b1;
            busCyc_o    <= 1'b0;
            fetchDone_o <= 1'b0;
        end else begin
            firstFetch  <= 1'b0;
            fetchDone_o <= 1'b0;
            if (ackSeen) begin
                busCyc_o    <= 1'b0;  // drop cyc the cycle after ack
                fetchDone_o <= 1'b1;
            end else if (start_i || firstFetch) begin
                busCyc_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            instr_o <= '0;
            pc_o    <= '0;
        end else if (ackSeen) begin
            pc_o <= pc_i;
            // keep the old instruction on an invalid slot
            if (busDat_i != busMapPkg::InvalidInstr) begin
                instr_o <= busDat_i;
            end
        end
    end

    // the CPU must not move pc while the read is still waiting for ack
    fetchAdrStable: assert property (
        @(posedge clk) disable iff (!nrst)
        (busCyc_o && !busAck_i) |=> $stable(pc_i)
    ) else $error("pc_i changed during a pending fetch");

endmodule

`default_nettype wire

// File: rtl/accessStage.sv
`timescale 1ns/1ps
`default_nettype none

module accessStage (
    input  wire logic             clk,
    input  wire logic             nrst,
    input  wire logic             fetchDone_i,
    input  memOpPkg::memOpT       memOp_i,
    input  wire logic             memSource_i,  // high picks the FPU register
    input  busMapPkg::wordT       aluAddr_i,
    input  busMapPkg::wordT       regData_i,
    input  busMapPkg::wordT       fpuData_i,
    output logic                  busCyc_o,
    output logic                  busWe_o,
    output busMapPkg::wordT       busAdr_o,
    output busMapPkg::selT        busSel_o,
    output busMapPkg::wordT       busDat_o,
    input  wire logic             busAck_i,
    input  busMapPkg::wordT       busDat_i,
    output busMapPkg::wordT       loadWord_o,
    output memOpPkg::memOpT       loadOp_o,
    output logic                  accessDone_o
);

    localparam int Dw = busMapPkg::DataWidth;

    logic                 doLoad;
    logic                 doStore;
    logic                 ackSeen;
    memOpPkg::accessSizeT size;
    busMapPkg::wordT      srcData;
    busMapPkg::wordT      storeData;
    busMapPkg::selT       storeSel;

    assign ackSeen = busCyc_o && busAck_i;

    // decode and store formatting
    always_comb begin
        doLoad  = memOpPkg::isLoad(memOp_i);
        doStore = memOpPkg::isStore(memOp_i);
        size    = memOpPkg::sizeOf(memOp_i);
        srcData = memSource_i ? fpuData_i : regData_i;
        case (size)
            memOpPkg::BYTE: begin
                storeData = {{(Dw-8){1'b0}}, srcData[7:0]};
                storeSel  = busMapPkg::SelByte;
            end
            memOpPkg::HALF: begin
                storeData = {{(Dw-16){1'b0}}, srcData[15:0]};
                storeSel  = busMapPkg::SelHalf;
            end
            default: begin
                storeData = srcData;
                storeSel  = busMapPkg::SelWord;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            busCyc_o     <= 1'b0;
            busWe_o      <= 1'b0;
            accessDone_o <= 1'b0;
            loadOp_o     <= memOpPkg::NONE;
        end else begin
            accessDone_o <= 1'b0;
            if (fetchDone_i) begin
                loadOp_o <= doLoad ? memOp_i : memOpPkg::NONE;
                if (doLoad || doStore) begin
                    busCyc_o <= 1'b1;
                    busWe_o  <= doStore;
                end else begin
                    accessDone_o <= 1'b1;  // no data phase, straight on
                end
            end else if (ackSeen) begin
                busCyc_o     <= 1'b0;
                busWe_o      <= 1'b0;
                accessDone_o <= 1'b1;
            end
        end
    end

    // request fields latched with the request, held until ack
    always_ff @(posedge clk) begin
        if (fetchDone_i) begin
            busAdr_o <= aluAddr_i;
            busSel_o <= doStore ? storeSel : busMapPkg::SelWord;  // loads read the whole word
            busDat_o <= doStore ? storeData : '0;
        end
        if (ackSeen && !busWe_o) begin
            loadWord_o <= busDat_i;  // raw word, extended in writeback
        end
    end

    // a new instruction never arrives while its data cycle is still open
    noFetchDuringAccess: assert property (
        @(posedge clk) disable iff (!nrst)
        fetchDone_i |-> !busCyc_o
    ) else $error("fetch completed during an open data cycle");

endmodule

`default_nettype wire

// File: rtl/writebackStage.sv
`timescale 1ns/1ps
`default_nettype none

module writebackStage (
    input  wire logic             clk,
    input  wire logic             nrst,
    input  wire logic             accessDone_i,
    input  memOpPkg::memOpT       loadOp_i,
    input  busMapPkg::wordT       loadWord_i,
    output busMapPkg::wordT       regData_o,
    output logic                  freeze_o
);

    localparam int Dw = busMapPkg::DataWidth;

    logic                 signedLoad;
    logic                 fillBit;
    memOpPkg::accessSizeT size;
    busMapPkg::wordT      extended;

    always_comb begin
        signedLoad = (loadOp_i == memOpPkg::LB) || (loadOp_i == memOpPkg::LH);
        size       = memOpPkg::sizeOf(loadOp_i);
        fillBit    = 1'b0;
        case (size)
            memOpPkg::BYTE: begin
                fillBit  = signedLoad && loadWord_i[7];
                extended = {{(Dw-8){fillBit}}, loadWord_i[7:0]};
            end
            memOpPkg::HALF: begin
                fillBit  = signedLoad && loadWord_i[15];
                extended = {{(Dw-16){fillBit}}, loadWord_i[15:0]};
            end
            default: extended = loadWord_i;  // LW
        endcase
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            regData_o <= '0;
            freeze_o  <= 1'b1;  // CPU held until the first instruction is done
        end else begin
            freeze_o <= !accessDone_i;  // release for a single cycle
            if (accessDone_i && memOpPkg::isLoad(loadOp_i)) begin
                regData_o <= extended;
            end
        end
    end

    // accessDone is a pulse, so the release must end after one cycle
    singleRelease: assert property (
        @(posedge clk) disable iff (!nrst)
        !freeze_o |=> freeze_o
    ) else $error("freeze_o low for more than one cycle");

endmodule

`default_nettype wire

// File: rtl/busArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module busArbiter (
    input  wire logic             clk,
    input  wire logic             nrst,
    input  wire logic             fetchCyc_i,
    input  busMapPkg::wordT       fetchAdr_i,
    output logic                  fetchAck_o,
    input  wire logic             accCyc_i,
    input  wire logic             accWe_i,
    input  busMapPkg::wordT       accAdr_i,
    input  busMapPkg::selT        accSel_i,
    input  busMapPkg::wordT       accDat_i,
    output logic                  accAck_o,
    output logic                  wbCyc_o,
    output logic                  wbStb_o,
    output logic                  wbWe_o,
    output busMapPkg::wordT       wbAdr_o,
    output busMapPkg::selT        wbSel_o,
    output busMapPkg::wordT       wbDat_o,
    input  wire logic             wbAck_i
);

    logic busy;      // a cycle has started and not yet seen ack
    logic grantAcc;  // owner of that cycle
    logic useAcc;

    // while idle the grant follows the requester, then stays locked
    assign useAcc = busy ? grantAcc : accCyc_i;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            busy     <= 1'b0;
            grantAcc <= 1'b0;
        end else if (busy) begin
            if (wbAck_i) busy <= 1'b0;
        end else if ((fetchCyc_i || accCyc_i) && !wbAck_i) begin
            busy     <= 1'b1;
            grantAcc <= accCyc_i;
        end
    end

    assign wbCyc_o = useAcc ? accCyc_i : fetchCyc_i;
    assign wbStb_o = wbCyc_o;  // classic, one transfer per cycle
    assign wbWe_o  = useAcc && accWe_i;
    assign wbAdr_o = useAcc ? accAdr_i : fetchAdr_i;
    assign wbSel_o = useAcc ? accSel_i : busMapPkg::SelWord;
    assign wbDat_o = useAcc ? accDat_i : '0;

    assign fetchAck_o = wbAck_i && wbCyc_o && !useAcc;
    assign accAck_o   = wbAck_i && wbCyc_o && useAcc;

    // the stages take turns; overlapping requests would break ack routing
    noOverlap: assert property (
        @(posedge clk) disable iff (!nrst)
        !(fetchCyc_i && accCyc_i)
    ) else $error("fetch and access requested the bus together");

endmodule

`default_nettype wire

// File: rtl/memHandlerTop.sv
`timescale 1ns/1ps
`default_nettype none

module memHandlerTop (
    input  wire logic             clk,
    input  wire logic             nrst,
    // CPU side
    input  busMapPkg::wordT       pc_i,
    input  memOpPkg::memOpT       memOp_i,
    input  wire logic             memSource_i,
    input  busMapPkg::wordT       aluAddr_i,
    input  busMapPkg::wordT       regData_i,
    input  busMapPkg::wordT       fpuData_i,
    output busMapPkg::wordT       instr_o,
    output busMapPkg::wordT       pc_o,
    output busMapPkg::wordT       regData_o,
    output logic                  freeze_o,
    // Wishbone master
    output logic                  wbCyc_o,
    output logic                  wbStb_o,
    output logic                  wbWe_o,
    output busMapPkg::wordT       wbAdr_o,
    output busMapPkg::selT        wbSel_o,
    output busMapPkg::wordT       wbDat_o,
    input  busMapPkg::wordT       wbDat_i,
    input  wire logic             wbAck_i
);

    logic            fetchStart;
    logic            fetchCyc;
    busMapPkg::wordT fetchAdr;
    logic            fetchAck;
    logic            fetchDone;
    logic            accCyc;
    logic            accWe;
    busMapPkg::wordT accAdr;
    busMapPkg::selT  accSel;
    busMapPkg::wordT accDat;
    logic            accAck;
    busMapPkg::wordT loadWord;
    memOpPkg::memOpT loadOp;
    logic            accessDone;

    assign fetchStart = !freeze_o;  // next fetch follows the release cycle

    fetchStage i_fetch (
        .clk(clk), .nrst(nrst), .start_i(fetchStart), .pc_i(pc_i),
        .busCyc_o(fetchCyc), .busAdr_o(fetchAdr), .busAck_i(fetchAck), .busDat_i(wbDat_i),
        .instr_o(instr_o), .pc_o(pc_o), .fetchDone_o(fetchDone)
    );

    accessStage i_access (
        .clk(clk), .nrst(nrst), .fetchDone_i(fetchDone), .memOp_i(memOp_i),
        .memSource_i(memSource_i), .aluAddr_i(aluAddr_i), .regData_i(regData_i),
        .fpuData_i(fpuData_i), .busCyc_o(accCyc), .busWe_o(accWe), .busAdr_o(accAdr),
        .busSel_o(accSel), .busDat_o(accDat), .busAck_i(accAck), .busDat_i(wbDat_i),
        .loadWord_o(loadWord), .loadOp_o(loadOp), .accessDone_o(accessDone)
    );

    writebackStage i_writeback (
        .clk(clk), .nrst(nrst), .accessDone_i(accessDone), .loadOp_i(loadOp),
        .loadWord_i(loadWord), .regData_o(regData_o), .freeze_o(freeze_o)
    );

    busArbiter i_arbiter (
        .clk(clk), .nrst(nrst),
        .fetchCyc_i(fetchCyc), .fetchAdr_i(fetchAdr), .fetchAck_o(fetchAck),
        .accCyc_i(accCyc), .accWe_i(accWe), .accAdr_i(accAdr), .accSel_i(accSel),
        .accDat_i(accDat), .accAck_o(accAck),
        .wbCyc_o(wbCyc_o), .wbStb_o(wbStb_o), .wbWe_o(wbWe_o), .wbAdr_o(wbAdr_o),
        .wbSel_o(wbSel_o), .wbDat_o(wbDat_o), .wbAck_i(wbAck_i)
    );

endmodule

`default_nettype wire

// File: dv/wbMemModel.sv
`timescale 1ns/1ps
`default_nettype none

module wbMemModel #(
    parameter int Seed = 32'h9048495b
) (
    input  wire logic             clk,
    input  wire logic             nrst,
    input  wire logic             wbCyc_i,
    input  wire logic             wbStb_i,
    input  wire logic             wbWe_i,
    input  busMapPkg::wordT       wbAdr_i,
    input  busMapPkg::selT        wbSel_i,
    input  busMapPkg::wordT       wbDat_i,
    output busMapPkg::wordT       wbDat_o,
    output logic                  wbAck_o
);

    busMapPkg::wordT mem [0:255];  // word addressed, adr[9:2]
    int              seed;
    logic            pending;
    logic [1:0]      waitCnt;

    initial seed = Seed;

    // testbench loads instruction and data words through this
    task automatic preload(input busMapPkg::wordT adr, input busMapPkg::wordT data);
        mem[adr[9:2]] = data;
    endtask

    assign wbDat_o = mem[wbAdr_i[9:2]];

    always @(posedge clk) begin
        wbAck_o <= 1'b0;
        if (!nrst) begin
            pending <= 1'b0;
            waitCnt <= 2'd0;
        end else if (wbCyc_i && wbStb_i && !wbAck_o) begin
            if (!pending) begin
                pending <= 1'b1;
                waitCnt <= 2'($random(seed) & 3);  // 0 to 3 wait cycles
            end else if (waitCnt == 2'd0) begin
                wbAck_o <= 1'b1;
                pending <= 1'b0;
                if (wbWe_i) begin
                    for (int b = 0; b < 4; b++) begin
                        if (wbSel_i[b]) mem[wbAdr_i[9:2]][b*8 +: 8] <= wbDat_i[b*8 +: 8];
                    end
                end
            end else begin
                waitCnt <= waitCnt - 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// File: dv/memHandlerTb.sv
`timescale 1ns/1ps
`default_nettype none

module memHandlerTb;

    localparam int NumTests = 12;

    logic clk = 1'b0;
    logic nrst = 1'b0;
    busMapPkg::wordT pc, aluAddr, regData, fpuData, instr, pcOut, regOut;
    busMapPkg::wordT wbAdr, wbDatM, wbDatS;
    busMapPkg::selT  wbSel;
    memOpPkg::memOpT memOp;
    logic memSource, freeze, wbCyc, wbStb, wbWe, wbAck;

    string           tName [NumTests];
    busMapPkg::wordT tPc [NumTests], tInstr [NumTests], tAdr [NumTests], tReg [NumTests];
    busMapPkg::wordT tFpu [NumTests], tMem [NumTests], tExp [NumTests];
    logic [3:0]      tOp [NumTests];
    logic            tSrc [NumTests];
    int              entryCount = 0;

    int seed = 32'h9048495b;
    int ackCount, writeCount, errorCount, passCount, failCount;
    int expCycles;
    logic testBad, lastFreezeLow;
    busMapPkg::wordT wrAdr, wrDat, expInstr;
    busMapPkg::selT  wrSel;

    always #4 clk = ~clk;

    memHandlerTop i_dut (
        .clk(clk), .nrst(nrst), .pc_i(pc), .memOp_i(memOp), .memSource_i(memSource),
        .aluAddr_i(aluAddr), .regData_i(regData), .fpuData_i(fpuData),
        .instr_o(instr), .pc_o(pcOut), .regData_o(regOut), .freeze_o(freeze),
        .wbCyc_o(wbCyc), .wbStb_o(wbStb), .wbWe_o(wbWe), .wbAdr_o(wbAdr), .wbSel_o(wbSel),
        .wbDat_o(wbDatM), .wbDat_i(wbDatS), .wbAck_i(wbAck)
    );

    wbMemModel #(.Seed(32'h9048495b)) i_mem (
        .clk(clk), .nrst(nrst), .wbCyc_i(wbCyc), .wbStb_i(wbStb), .wbWe_i(wbWe),
        .wbAdr_i(wbAdr), .wbSel_i(wbSel), .wbDat_i(wbDatM), .wbDat_o(wbDatS), .wbAck_o(wbAck)
    );

    task automatic addEntry(input string name, input busMapPkg::wordT p, ins, input logic [3:0] op,
                            input logic src, input busMapPkg::wordT adr, rd, fd, mw, ex);
        tName[entryCount] = name;
        tPc[entryCount] = p;
        tInstr[entryCount] = ins;
        tOp[entryCount] = op;
        tSrc[entryCount] = src;
        tAdr[entryCount] = adr;
        tReg[entryCount] = rd;
        tFpu[entryCount] = fd;
        tMem[entryCount] = mw;
        tExp[entryCount] = ex;
        entryCount++;
    endtask

    function automatic logic storeOp(input logic [3:0] op);
        return op == 4'd6 || op == 4'd7 || op == 4'd8;
    endfunction

    function automatic busMapPkg::selT expectSel(input logic [3:0] op);
        case (op)
            4'd6:    return 4'b0001;
            4'd7:    return 4'b0011;
            default: return 4'b1111;
        endcase
    endfunction

    task automatic checkWord(input string name, input busMapPkg::wordT exp, act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %h actual %h", name, exp, act);
            testBad = 1'b1;
        end
    endtask

    task automatic checkSel(input string name, input busMapPkg::selT exp, act);
        if (exp !== act) begin
            $display("MISMATCH %s expected %b actual %b", name, exp, act);
            testBad = 1'b1;
        end
    endtask

    // preload and drive the CPU side for one entry
    task automatic applyEntry(input int i);
        i_mem.preload(tPc[i], tInstr[i]);
        i_mem.preload(tAdr[i], tMem[i]);
        ackCount = 0;
        writeCount = 0;
        pc <= tPc[i];
        memOp <= memOpPkg::memOpT'(tOp[i]);
        memSource <= tSrc[i];
        aluAddr <= tAdr[i];
        regData <= tReg[i];
        fpuData <= tFpu[i];
    endtask

    // bus and release monitor
    always @(posedge clk) begin
        if (nrst) begin
            if (wbCyc && wbAck) begin
                ackCount++;
                if (wbWe) begin
                    writeCount++;
                    wrAdr = wbAdr;
                    wrSel = wbSel;
                    wrDat = wbDatM;
                end
            end
            if (wbStb !== wbCyc) begin
                $display("error: wbStb_o does not follow wbCyc_o");
                errorCount++;
            end
            if (!freeze && wbCyc) begin
                $display("error: freeze_o low while a bus cycle is open");
                errorCount++;
            end
            if (!freeze && lastFreezeLow) begin
                $display("error: freeze_o low for two cycles in a row");
                errorCount++;
            end
            lastFreezeLow = !freeze;
        end
    end

    initial begin
        repeat (NumTests * 40) @(posedge clk);
        $display("timeout: no release from the DUT within %0d cycles", NumTests * 40);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        //        name       pc      instr      op  src adr     reg        fpu        mem        expected
        addEntry("lw",       'h000, 'h00002083, 3, 0, 'h200, 'h0,       'h0,       'h80008080, 'h80008080);
        addEntry("lb",       'h004, 'h00400103, 1, 0, 'h204, 'h0,       'h0,       'h1234C0F1, 'hFFFFFFF1);
        addEntry("lbu",      'h008, 'h00804183, 4, 0, 'h208, 'h0,       'h0,       'h5678A09C, 'h0000009C);
        addEntry("lh",       'h00C, 'h00C01203, 2, 0, 'h20C, 'h0,       'h0,       'h0BADC3A5, 'hFFFFC3A5);
        addEntry("lhu",      'h010, 'h01005283, 5, 0, 'h210, 'h0,       'h0,       'h77779E81, 'h00009E81);
        addEntry("sb_reg",   'h014, 'h00A00023, 6, 0, 'h280, 'hCAFEF00D, 'h11112222, 'h0,       'h0000000D);
        addEntry("sh_fpu",   'h018, 'h00B01023, 7, 1, 'h284, 'hAAAABBBB, 'h33334567, 'h0,       'h00004567);
        addEntry("sw_reg",   'h01C, 'h00C02023, 8, 0, 'h288, 'h89ABCDEF, 'h0,       'h0,       'h89ABCDEF);
        addEntry("sw_fpu",   'h020, 'h00D02027, 8, 1, 'h28C, 'h01010101, 'hFEDCBA98, 'h0,       'hFEDCBA98);
        addEntry("none",     'h024, 'h00000013, 0, 0, 'h300, 'h0,       'h0,       'h0,       'h00009E81);
        addEntry("invalid",  'h028, 'hDEADBEEF, 0, 0, 'h304, 'h0,       'h0,       'h0,       'h00009E81);
        addEntry("unused12", 'h02C, 'h00100093, 12, 0, 'h308, 'h0,      'h0,       'h0,       'h00009E81);

        // filler tied to the full word index
        for (int a = 0; a < 256; a++) i_mem.preload(a * 4, $random(seed) ^ (a * 32'h01010101));
        errorCount = 0;
        lastFreezeLow = 1'b0;
        expInstr = '0;
        applyEntry(0);
        repeat (3) @(posedge clk);
        nrst <= 1'b1;

        for (int i = 0; i < NumTests; i++) begin
            do @(posedge clk); while (freeze);  // release pulse
            testBad = 1'b0;
            if (tInstr[i] != 32'hDEADBEEF) expInstr = tInstr[i];
            checkWord({tName[i], " instr"}, expInstr, instr);
            checkWord({tName[i], " pc"}, tPc[i], pcOut);
            expCycles = (tOp[i] inside {[1:8]}) ? 2 : 1;
            if (ackCount != expCycles) begin
                $display("MISMATCH %s bus cycles expected %0d actual %0d",
                         tName[i], expCycles, ackCount);
                testBad = 1'b1;
            end
            if (storeOp(tOp[i])) begin
                if (writeCount != 1) begin
                    $display("MISMATCH %s write cycles expected 1 actual %0d",
                             tName[i], writeCount);
                    testBad = 1'b1;
                end
                checkWord({tName[i], " adr"}, tAdr[i], wrAdr);
                checkSel({tName[i], " sel"}, expectSel(tOp[i]), wrSel);
                checkWord({tName[i], " data"}, tExp[i], wrDat);
            end else begin
                checkWord({tName[i], " regData"}, tExp[i], regOut);
            end
            if (testBad) failCount++;
            else passCount++;
            $display("%-9s %s", tName[i], testBad ? "fail" : "ok");
            if (i + 1 < NumTests) applyEntry(i + 1);
        end

        @(posedge clk);
        $display("tests ok %0d, failed %0d, monitor errors %0d", passCount, failCount, errorCount);
        if (failCount == 0 && errorCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: list.f
rtl/memOpPkg.sv
rtl/busMapPkg.sv
rtl/fetchStage.sv
rtl/accessStage.sv
rtl/writebackStage.sv
rtl/busArbiter.sv
rtl/memHandlerTop.sv
dv/wbMemModel.sv
dv/memHandlerTb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -Wno-fatal -f list.f --top-module memHandlerTb -o simv

out=$(./obj_dir/simv)
echo "$out"

if echo "$out" | grep -q '^\*\*\* PASSED \*\*\*$'; then
    exit 0
else
    exit 1
fi
